// ==== src/icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int ADDR_W     = 19;     // fetch byte address
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 8;
    localparam int LINE_WORDS = 16;     // 64 byte lines

    // upper bits left over after set, word and byte offset
    typedef logic [ADDR_W-$clog2(NUM_SETS*LINE_WORDS*4)-1:0] tag_t;
    typedef logic [$clog2(NUM_SETS)-1:0]                     set_idx_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]                   word_idx_t;
    typedef logic [$clog2(NUM_SETS*LINE_WORDS)-1:0]          word_addr_t;   // {set, word}
    typedef logic [31:0]                                     instr_t;
    typedef logic [NUM_WAYS-1:0]                             way_onehot_t;

    // tag 18:9, set 8:6, word 5:2
    typedef struct packed {
        tag_t       tag;
        set_idx_t   set_idx;
        word_idx_t  word_idx;
        logic [1:0] byte_off;   // always 0 for fetches
    } fetch_addr_t;

    typedef enum logic [1:0] {
        SLEEP,      // cache off, all lines invalid
        IDLE,
        LOOKUP,     // tag compare of the granted fetch
        REFILL      // line coming in from the next level
    } ctrl_state_t;

endpackage

// ==== src/icache_sram.sv ====
`timescale 1ns/10ps

module icache_sram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 8
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  word_t                    wdata,
    output word_t                    rdata
);

    word_t mem [DEPTH];

    // single port, read data one cycle after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];     // rdata holds on write cycles
        end
    end

endmodule

// ==== src/icache_power_ctrl.sv ====
`timescale 1ns/10ps

module icache_power_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic work_en,
    input  logic sleep_en,
    input  logic sleep_ack,
    output logic cache_on,
    output logic sleep_pending
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_on      <= 1'b0;
            sleep_pending <= 1'b0;
        end else begin
            // a wake in the ack cycle is kept
            cache_on      <= work_en | (cache_on & ~sleep_ack);
            // sleep pulse waits here until the fsm reaches idle
            sleep_pending <= sleep_en | (sleep_pending & ~sleep_ack);
        end
    end

    // controller only acks a request it was given
    a_ack_needs_pending: assert property (
        @(posedge clk) disable iff (!rst_n) sleep_ack |-> sleep_pending
    );

endmodule

// ==== src/icache_plru.sv ====
`timescale 1ns/10ps

module icache_plru (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    touch,
    input  icache_pkg::set_idx_t    touch_set,
    input  icache_pkg::way_onehot_t touch_way,
    input  icache_pkg::way_onehot_t valid_mask,
    input  icache_pkg::set_idx_t    lookup_set,
    output icache_pkg::way_onehot_t victim_way
);

    import icache_pkg::*;

    // per set: [0] root, 1 = upper pair used last
    // [1] lower pair, 1 = way 1 used last; [2] upper pair, 1 = way 3 used last
    logic [2:0]  tree [NUM_SETS];
    logic [2:0]  cur;
    way_onehot_t invalid;
    way_onehot_t tree_victim;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree <= '{default: '0};
        end else if (flush) begin
            tree <= '{default: '0};
        end else if (touch) begin
            if (touch_way[0] | touch_way[1]) begin
                tree[touch_set][0] <= 1'b0;
                tree[touch_set][1] <= touch_way[1];
            end else begin
                tree[touch_set][0] <= 1'b1;
                tree[touch_set][2] <= touch_way[3];
            end
        end
    end

    assign cur     = tree[lookup_set];
    assign invalid = ~valid_mask;

    // walk away from the recently used side
    always_comb begin
        if (cur[0])
            tree_victim = cur[1] ? 4'b0001 : 4'b0010;
        else
            tree_victim = cur[2] ? 4'b0100 : 4'b1000;
    end

    // lowest invalid way first, tree only once the set is full
    assign victim_way = (|invalid) ? (invalid & (~invalid + way_onehot_t'(1))) : tree_victim;

    a_victim_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot(victim_way)
    );

endmodule

// ==== src/icache_refill.sv ====
`timescale 1ns/10ps

module icache_refill (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss_start,
    input  icache_pkg::fetch_addr_t miss_addr,
    input  logic                    refill_gnt,
    input  logic                    refill_r_valid,
    input  icache_pkg::instr_t      refill_r_data,
    output logic                    refill_req,
    output icache_pkg::fetch_addr_t refill_addr,
    output logic                    fill_valid,
    output icache_pkg::word_idx_t   fill_word,
    output icache_pkg::instr_t      fill_data,
    output logic                    refill_done
);

    import icache_pkg::*;

    logic      active;      // granted, words still to come
    word_idx_t cnt;         // next word index of the line
    logic      last_word;

    assign fill_valid = active & refill_r_valid;
    assign fill_word  = cnt;
    assign fill_data  = refill_r_data;
    assign last_word  = fill_valid && (cnt == word_idx_t'(LINE_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refill_req  <= 1'b0;
            active      <= 1'b0;
            cnt         <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= last_word;           // one cycle after word 16
            if (miss_start)
                refill_req <= 1'b1;
            else if (refill_gnt)
                refill_req <= 1'b0;             // held until granted
            if (refill_req & refill_gnt) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (last_word) begin
                active <= 1'b0;
            end
            if (fill_valid)
                cnt <= cnt + 1'b1;              // words arrive in address order
        end
    end

    // line aligned request address
    always_ff @(posedge clk) begin
        if (miss_start)
            refill_addr <= '{tag: miss_addr.tag, set_idx: miss_addr.set_idx, default: '0};
    end

    a_no_data_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) refill_r_valid |-> active
    );

endmodule

// ==== src/icache_way_array.sv ====
`timescale 1ns/10ps

module icache_way_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_en,
    input  icache_pkg::fetch_addr_t lookup_addr,
    input  logic                    miss_start,
    input  icache_pkg::way_onehot_t victim_way,
    input  logic                    fill_valid,
    input  icache_pkg::word_idx_t   fill_word,
    input  icache_pkg::instr_t      fill_data,
    input  logic                    refill_done,
    input  logic                    flush,
    output logic                    hit,
    output icache_pkg::way_onehot_t hit_way,
    output icache_pkg::instr_t      hit_data,
    output icache_pkg::set_idx_t    fill_set,
    output icache_pkg::way_onehot_t valid_mask
);

    import icache_pkg::*;

    fetch_addr_t addr_q;            // fetch under compare, held through a refill
    way_onehot_t victim_q;          // way being refilled
    logic        filling;
    way_onehot_t valid [NUM_SETS];
    way_onehot_t match;
    way_onehot_t tag_we;
    way_onehot_t data_we;
    set_idx_t    tag_addr;
    word_addr_t  data_addr;
    tag_t        tag_rd  [NUM_WAYS];
    instr_t      data_rd [NUM_WAYS];

    // fill words own the bank port during a refill, lookups otherwise
    assign tag_addr  = fill_valid ? addr_q.set_idx : lookup_addr.set_idx;
    assign data_addr = fill_valid ? {addr_q.set_idx, fill_word}
                                  : {lookup_addr.set_idx, lookup_addr.word_idx};
    assign data_we   = fill_valid ? victim_q : '0;
    assign tag_we    = (fill_valid && fill_word == '0) ? victim_q : '0;   // tag goes in with word 0

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        icache_sram #(.word_t(tag_t), .DEPTH(NUM_SETS)) u_tag (
            .clk   (clk),
            .en    (lookup_en | tag_we[w]),
            .we    (tag_we[w]),
            .addr  (tag_addr),
            .wdata (addr_q.tag),
            .rdata (tag_rd[w])
        );
        icache_sram #(.word_t(instr_t), .DEPTH(NUM_SETS * LINE_WORDS)) u_data (
            .clk   (clk),
            .en    (lookup_en | data_we[w]),
            .we    (data_we[w]),
            .addr  (data_addr),
            .wdata (fill_data),
            .rdata (data_rd[w])
        );
        assign match[w] = valid[addr_q.set_idx][w] && (tag_rd[w] == addr_q.tag);
    end

    always_comb begin
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (match[w])
                hit_data |= data_rd[w];
        end
    end

    assign hit        = |match;
    assign hit_way    = filling ? victim_q : match;   // fill way while refilling
    assign fill_set   = addr_q.set_idx;
    assign valid_mask = valid[addr_q.set_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q   <= '0;
            victim_q <= '0;
            filling  <= 1'b0;
            valid    <= '{default: '0};
        end else begin
            if (lookup_en)
                addr_q <= lookup_addr;
            if (miss_start) begin
                victim_q <= victim_way;
                filling  <= 1'b1;
            end else if (refill_done) begin
                filling  <= 1'b0;
            end
            if (flush)
                valid <= '{default: '0};       // sleep drops every line
            else if (refill_done)
                valid[addr_q.set_idx] <= valid[addr_q.set_idx] | victim_q;
        end
    end

    // refill never creates a second copy of a tag in one set
    a_hit_way_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_way)
    );

endmodule

// ==== src/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_req,
    input  icache_pkg::fetch_addr_t fetch_addr,
    input  logic                    cache_on,
    input  logic                    sleep_pending,
    input  logic                    hit,
    input  icache_pkg::instr_t      hit_data,
    input  icache_pkg::way_onehot_t hit_way,
    input  logic                    fill_valid,
    input  icache_pkg::word_idx_t   fill_word,
    input  icache_pkg::instr_t      fill_data,
    input  logic                    refill_done,
    output logic                    fetch_gnt,
    output logic                    fetch_r_valid,
    output icache_pkg::instr_t      fetch_r_data,
    output logic                    lookup_en,
    output icache_pkg::fetch_addr_t lookup_addr,
    output logic                    miss_start,
    output logic                    sleep_ack,
    output logic                    plru_touch,
    output icache_pkg::way_onehot_t touch_way
);

    import icache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nx;
    fetch_addr_t req_q;         // granted fetch address
    logic        can_grant;

    // no new grants once a sleep is waiting
    assign can_grant = fetch_req & cache_on & ~sleep_pending;

    assign lookup_en   = fetch_gnt;                         // bank read starts at grant
    assign lookup_addr = fetch_gnt ? fetch_addr : req_q;    // miss address to refill otherwise
    assign touch_way   = hit_way;                           // hit way, or fill way in refill

    always_comb begin
        state_nx      = state;
        fetch_gnt     = 1'b0;
        fetch_r_valid = 1'b0;
        fetch_r_data  = hit_data;
        miss_start    = 1'b0;
        sleep_ack     = 1'b0;
        plru_touch    = 1'b0;
        case (state)
            SLEEP: begin
                if (cache_on)
                    state_nx = IDLE;
            end
            IDLE: begin
                if (sleep_pending) begin
                    sleep_ack = 1'b1;       // flushes the arrays
                    state_nx  = SLEEP;
                end else if (can_grant) begin
                    fetch_gnt = 1'b1;
                    state_nx  = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    fetch_r_valid = 1'b1;
                    plru_touch    = 1'b1;
                    fetch_gnt     = can_grant;  // next fetch overlaps this return
                    state_nx      = can_grant ? LOOKUP : IDLE;
                end else begin
                    miss_start = 1'b1;
                    state_nx   = REFILL;
                end
            end
            REFILL: begin
                fetch_r_data = fill_data;
                // requested word goes out as it passes
                if (fill_valid && fill_word == req_q.word_idx)
                    fetch_r_valid = 1'b1;
                if (refill_done) begin
                    plru_touch = 1'b1;
                    state_nx   = IDLE;
                end
            end
            default: state_nx = SLEEP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= SLEEP;
        else
            state <= state_nx;
    end

    always_ff @(posedge clk) begin
        if (fetch_gnt)
            req_q <= fetch_addr;
    end

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_req,
    input  icache_pkg::fetch_addr_t fetch_addr,
    output logic                    fetch_gnt,
    output logic                    fetch_r_valid,
    output icache_pkg::instr_t      fetch_r_data,
    output logic                    refill_req,
    output icache_pkg::fetch_addr_t refill_addr,
    input  logic                    refill_gnt,
    input  logic                    refill_r_valid,
    input  icache_pkg::instr_t      refill_r_data,
    output logic                    refill_done,
    input  logic                    work_en,
    input  logic                    sleep_en
);

    import icache_pkg::*;

    logic        cache_on;
    logic        sleep_pending;
    logic        sleep_ack;         // also the array flush
    logic        lookup_en;
    logic        miss_start;
    logic        plru_touch;
    logic        hit;
    logic        fill_valid;
    fetch_addr_t lookup_addr;
    way_onehot_t hit_way;
    way_onehot_t touch_way;
    way_onehot_t victim_way;
    way_onehot_t valid_mask;
    instr_t      hit_data;
    instr_t      fill_data;
    word_idx_t   fill_word;
    set_idx_t    fill_set;          // set under compare or refill

    icache_power_ctrl u_power (.*);

    icache_ctrl u_ctrl (.*);

    icache_way_array u_ways (
        .*,
        .flush (sleep_ack)
    );

    icache_plru u_plru (
        .*,
        .flush      (sleep_ack),
        .touch      (plru_touch),
        .touch_set  (fill_set),
        .lookup_set (fill_set)
    );

    icache_refill u_refill (
        .*,
        .miss_addr (lookup_addr)    // carries the held fetch in the miss cycle
    );

endmodule

// ==== tb/icache_ref.svh ====
// xorshift step, also the stimulus rng
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// next-level memory content for byte address a
function automatic logic [31:0] l2_word(input logic [18:0] a);
    return xorshift32({a, 13'h1b3}) ^ {13'd0, a};
endfunction

// ==== tb/icache_checker.sv ====
`timescale 1ns/10ps

module icache_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        work_en,
    input  logic        sleep_en,
    input  logic [18:0] fetch_addr,
    input  logic        fetch_gnt,
    input  logic        fetch_r_valid,
    input  logic [31:0] fetch_r_data,
    input  logic        refill_req,
    input  logic [18:0] refill_addr,
    input  logic        refill_r_valid,
    input  logic        refill_done,
    output int          err_cnt,
    output int          chk_cnt,
    output logic        busy
);

    `include "icache_ref.svh"

    logic [9:0]  tags [8][4];   // model of the tag banks
    logic [3:0]  valid [8];
    logic [2:0]  tree [8];      // [0] upper half used last, [1] way 1, [2] way 3
    logic [18:0] addr_q [$];    // granted and not yet returned
    logic        hit_q [$];
    logic        awake, hit_due, expect_refill, in_refill, req_d, last_d;
    logic [18:0] miss_line;
    int          words;         // line words seen in this refill

    function automatic logic [1:0] pick_victim(input logic [3:0] v, input logic [2:0] t);
        for (int w = 0; w < 4; w++)
            if (!v[w]) return 2'(w);    // first invalid way
        if (t[0])
            return t[1] ? 2'd0 : 2'd1;
        return t[2] ? 2'd2 : 2'd3;
    endfunction

    task automatic touch(input logic [2:0] s, input logic [1:0] w);
        tree[s][0] = w[1];
        if (w[1])
            tree[s][2] = w[0];
        else
            tree[s][1] = w[0];
    endtask

    // predict hit or miss and update the model as the dut would
    task automatic model_lookup(input logic [18:0] a, output logic is_hit);
        logic [1:0] way;
        is_hit = 1'b0;
        way    = 2'd0;
        for (int w = 0; w < 4; w++) begin
            if (valid[a[8:6]][w] && tags[a[8:6]][w] == a[18:9]) begin
                is_hit = 1'b1;
                way    = 2'(w);
            end
        end
        if (!is_hit) begin
            way = pick_victim(valid[a[8:6]], tree[a[8:6]]);
            tags[a[8:6]][way]  = a[18:9];
            valid[a[8:6]][way] = 1'b1;
        end
        touch(a[8:6], way);
    endtask

    always @(negedge clk) begin : watch
        logic [18:0] a;
        logic        h;
        if (!rst_n) begin
            for (int s = 0; s < 8; s++) begin
                valid[s] = '0;
                tree[s]  = '0;
            end
            addr_q.delete();
            hit_q.delete();
            {awake, hit_due, expect_refill, in_refill, req_d, last_d} = '0;
            words   = 0;
            err_cnt = 0;
            chk_cnt = 0;
        end else begin
            if (fetch_r_valid) begin
                if (addr_q.size() == 0) begin
                    $display("error at %0t: fetch_r_valid with no fetch outstanding", $time);
                    err_cnt++;
                end else begin
                    a = addr_q.pop_front();
                    h = hit_q.pop_front();
                    chk_cnt++;
                    if (fetch_r_data !== l2_word(a)) begin
                        $display("CHECK FAILED at %0t: addr %h data %h, expected %h", $time, a,
                                 fetch_r_data, l2_word(a));
                        err_cnt++;
                    end
                    if (!h && !in_refill) begin
                        $display("error at %0t: addr %h hit but a miss was predicted", $time, a);
                        err_cnt++;
                        expect_refill = 1'b0;
                    end
                end
            end
            if (hit_due && !fetch_r_valid) begin
                $display("error at %0t: hit not returned one cycle after grant", $time);
                err_cnt++;
            end
            hit_due = 1'b0;
            if (refill_req && !req_d) begin     // new line request
                chk_cnt++;
                if (!expect_refill) begin
                    $display("error at %0t: unexpected refill request for %h", $time, refill_addr);
                    err_cnt++;
                end else if (refill_addr !== miss_line) begin
                    $display("CHECK FAILED at %0t: refill addr %h, expected %h", $time,
                             refill_addr, miss_line);
                    err_cnt++;
                end
                expect_refill = 1'b0;
                in_refill     = 1'b1;
                words         = 0;
            end
            req_d = refill_req;
            if (refill_done) begin
                chk_cnt++;
                if (!last_d) begin
                    $display("error at %0t: refill_done not one cycle after the sixteenth word",
                             $time);
                    err_cnt++;
                end
                in_refill = 1'b0;
                if (addr_q.size() != 0) begin
                    $display("error at %0t: refill ended before the fetch returned", $time);
                    err_cnt++;
                end
            end else if (last_d) begin
                $display("error at %0t: no refill_done after the sixteenth word", $time);
                err_cnt++;
            end
            last_d = 1'b0;
            if (refill_r_valid) begin
                words++;
                last_d = (words == 16);     // done pulse due next cycle
            end
            if (fetch_gnt) begin
                chk_cnt++;
                if (!awake || in_refill || expect_refill) begin
                    $display("error at %0t: grant while asleep, refilling or a miss is pending",
                             $time);
                    err_cnt++;
                end
                expect_refill = 1'b0;
                model_lookup(fetch_addr, h);
                addr_q.push_back(fetch_addr);
                hit_q.push_back(h);
                if (h)
                    hit_due = 1'b1;
                else begin
                    expect_refill = 1'b1;
                    miss_line     = {fetch_addr[18:6], 6'd0};
                end
            end
            if (work_en)
                awake = 1'b1;
            if (sleep_en) begin         // sleep drops all lines
                awake = 1'b0;
                for (int s = 0; s < 8; s++) begin
                    valid[s] = '0;
                    tree[s]  = '0;
                end
            end
        end
        busy = (addr_q.size() != 0) || in_refill || expect_refill;
    end

endmodule

// ==== tb/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;

    `include "icache_ref.svh"

    localparam logic [31:0] SEED  = 32'h0c28_cd73;
    localparam int          LIMIT = 60 * 80 + 500;  // fetches x worst miss, plus sleep and reset

    logic        clk, rst_n, fetch_req, fetch_gnt, fetch_r_valid, refill_req, refill_gnt;
    logic        refill_r_valid, refill_done, work_en, sleep_en, busy, bp_mode;
    logic [18:0] fetch_addr, refill_addr, a0;
    logic [31:0] fetch_r_data, refill_r_data, rng, r;
    int          err_cnt, chk_cnt, tb_err, cycles, gnt_cycle, first;

    icache_top dut0 (.*);

    icache_checker chk0 (.*);

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [18:0] mk_addr(input logic [9:0] tag, input logic [2:0] set,
                                            input logic [3:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    task automatic fetch(input logic [18:0] a);
        fetch_req  = 1'b1;
        fetch_addr = a;
        @(negedge clk);
        while (!fetch_gnt)
            @(negedge clk);
        gnt_cycle = cycles;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
    endtask

    task automatic settle();
        @(posedge clk);
        while (busy)
            @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic power_pulse(input logic to_sleep, input int wait_cycles);
        if (to_sleep)
            sleep_en = 1'b1;
        else
            work_en = 1'b1;
        @(posedge clk);
        #1;
        sleep_en = 1'b0;
        work_en  = 1'b0;
        repeat (wait_cycles) @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < LIMIT)
            @(posedge clk) cycles++;
        $display("timeout: run passed %0d cycles without finishing", LIMIT);
        $display("Some tests failed");
        $finish;
    end

    // next level model with random grant delay and word gaps
    initial begin : l2_model
        logic [18:0] base;
        int          delay, gap;
        forever begin
            @(negedge clk);
            if (rst_n && refill_req) begin
                base  = refill_addr;
                r     = rand32();
                delay = bp_mode ? int'(r % 8) : int'(r % 2);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                refill_gnt = 1'b1;
                @(posedge clk);
                #1;
                refill_gnt = 1'b0;
                for (int i = 0; i < 16; i++) begin
                    r   = rand32();
                    gap = bp_mode ? int'(r % 4) : 0;
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    refill_r_valid = 1'b1;
                    refill_r_data  = l2_word(base + 19'(i * 4));
                    @(posedge clk);
                    #1;
                    refill_r_valid = 1'b0;
                end
            end
        end
    end

    initial begin
        {rst_n, fetch_req, refill_gnt, refill_r_valid, work_en, sleep_en, bp_mode} = '0;
        fetch_addr    = '0;
        refill_r_data = '0;
        rng           = SEED;
        tb_err        = 0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        // held request while asleep is never granted
        fetch_req  = 1'b1;
        fetch_addr = mk_addr(10'h012, 3'd1, 4'd5);
        repeat (20) @(posedge clk);
        #1 fetch_req = 1'b0;
        power_pulse(1'b0, 3);
        a0 = mk_addr(10'h012, 3'd1, 4'd5);  // cold miss
        fetch(a0);
        settle();
        for (int w = 0; w < 16; w++) begin  // rest of the line back to back
            if (w != 5) begin
                fetch(mk_addr(10'h012, 3'd1, 4'(w)));
                if (w == 0)
                    first = gnt_cycle;
            end
        end
        if (gnt_cycle - first != 14) begin
            $display("error: hit stream took %0d cycles for 15 grants", gnt_cycle - first + 1);
            tb_err++;
        end
        settle();
        for (int n = 0; n < 24; n++) begin  // five lines fighting over set 6
            r = rand32();
            fetch(mk_addr(10'(64 + int'(r % 5) * 91), 3'd6, r[11:8]));
        end
        settle();
        fetch(a0);
        settle();
        power_pulse(1'b1, 4);
        power_pulse(1'b0, 3);
        fetch(a0);                          // flushed so it refills again
        settle();
        bp_mode = 1'b1;
        for (int n = 0; n < 10; n++) begin
            r = rand32();
            fetch({8'd0, r[10:2], 2'b00});
        end
        settle();
        $display("closing: %0d errors in %0d checks", err_cnt + tb_err, chk_cnt);
        if (err_cnt + tb_err == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== icache.f ====
+incdir+tb
src/icache_pkg.sv
src/icache_sram.sv
src/icache_power_ctrl.sv
src/icache_plru.sv
src/icache_refill.sv
src/icache_way_array.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 -f icache.f --top-module icache_tb \
    -o icache_sim > build.log 2>&1 \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
